/* Makefile */
TOP := tb_pcie_ingress

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert --timescale 1ns/1ns -f verilog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f verilog.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) | awk '{ print } /^STATUS: PASS$$/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir

/* rtl/cpl_buffer_writer.sv */
/*
  Completion payload writer.
  Payload lands at i_buf_offset plus the lower address in dwords, then increments.
  The summary pulse comes one cycle after the final buffer write.
*/
`default_nettype none

module cpl_buffer_writer (
  input  wire                               clk,
  input  wire                               rst,
  input  wire pcie_ingress_pkg::route_req_t i_req,
  input  wire [pcie_ingress_pkg::BUF_ADDR_W-1:0] i_buf_offset,
  output logic                              o_done,
  output pcie_ingress_pkg::buf_wr_t         o_buf,
  output pcie_ingress_pkg::cplt_info_t      o_cplt
);
  import pcie_ingress_pkg::*;

  logic                  we;
  logic [BUF_ADDR_W-1:0] addr;
  logic [31:0]           data;
  logic                  last_wr;
  logic                  cplt_stb;
  logic [7:0]            tag;
  logic [11:0]           byte_cnt;
  logic [9:0]            dw_cnt;

  assign o_done = i_req.stb && i_req.last;

  always_ff @(posedge clk) begin
    if (rst) begin
      we       <= 1'b0;
      last_wr  <= 1'b0;
      cplt_stb <= 1'b0;
    end else begin
      we       <= i_req.stb;
      last_wr  <= i_req.stb && i_req.last;
      cplt_stb <= last_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (i_req.stb) begin
      data <= i_req.data;
      addr <= i_req.first ? i_buf_offset + BUF_ADDR_W'(i_req.lower_addr[6:2])
                          : addr + BUF_ADDR_W'(1);
      if (i_req.last) begin
        tag      <= i_req.tag;
        byte_cnt <= i_req.byte_cnt;
        dw_cnt   <= i_req.dw_cnt;
      end
    end
  end

  assign o_buf  = '{we: we, addr: addr, data: data};
  assign o_cplt = '{stb: cplt_stb, tag: tag, byte_cnt: byte_cnt, dw_cnt: dw_cnt};

endmodule

`default_nettype wire

/* rtl/ctrl_reg_decoder.sv */
/*
  Control window decoder for memory writes.
  Only the first payload dword of a write is used, the rest are consumed silently.
  Indices below CMD_OFFSET load setup registers, the others raise a command event.
  Command payload fields are only meaningful while o_cmd.stb is high.
*/
`default_nettype none

module ctrl_reg_decoder (
  input  wire                               clk,
  input  wire                               rst,
  input  wire pcie_ingress_pkg::route_req_t i_req,
  output logic                              o_done,
  output pcie_ingress_pkg::ctrl_regs_t      o_regs,
  output logic                              o_reg_write_stb,
  output logic                              o_update_buf_stb,
  output pcie_ingress_pkg::cmd_event_t      o_cmd
);
  import pcie_ingress_pkg::*;

  logic        act;
  logic        is_cmd;
  cmd_kind_e   dec_kind;
  cmd_sel_e    dec_sel;
  logic        dec_fifo;
  logic        cmd_stb;
  cmd_kind_e   cmd_kind;
  cmd_sel_e    cmd_sel;
  logic        cmd_fifo;
  logic [31:0] cmd_data;

  assign o_done = i_req.stb && i_req.last;
  assign act    = i_req.stb && i_req.first;
  assign is_cmd = (i_req.reg_idx >= CMD_OFFSET);

  // Command table
  always_comb begin
    dec_sel  = SEL_NONE;
    dec_fifo = 1'b0;
    case (i_req.reg_idx)
      CMD_RESET:          dec_kind = KIND_RESET;
      CMD_PER_WRITE: begin
        dec_kind = KIND_WRITE;
        dec_sel  = SEL_PER;
      end
      CMD_PER_WRITE_FIFO: begin
        dec_kind = KIND_WRITE;
        dec_sel  = SEL_PER;
        dec_fifo = 1'b1;
      end
      CMD_PER_READ: begin
        dec_kind = KIND_READ;
        dec_sel  = SEL_PER;
      end
      CMD_PER_READ_FIFO: begin
        dec_kind = KIND_READ;
        dec_sel  = SEL_PER;
        dec_fifo = 1'b1;
      end
      CMD_MEM_WRITE: begin
        dec_kind = KIND_WRITE;
        dec_sel  = SEL_MEM;
      end
      CMD_MEM_READ: begin
        dec_kind = KIND_READ;
        dec_sel  = SEL_MEM;
      end
      CMD_DMA_WRITE: begin
        dec_kind = KIND_WRITE;
        dec_sel  = SEL_DMA;
      end
      CMD_DMA_READ: begin
        dec_kind = KIND_READ;
        dec_sel  = SEL_DMA;
      end
      CMD_PING:           dec_kind = KIND_PING;
      CMD_READ_CONFIG:    dec_kind = KIND_READ_CONFIG;
      default:            dec_kind = KIND_UNKNOWN;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      o_regs           <= '0;
      o_reg_write_stb  <= 1'b0;
      o_update_buf_stb <= 1'b0;
      cmd_stb          <= 1'b0;
    end else begin
      o_reg_write_stb  <= 1'b0;
      o_update_buf_stb <= 1'b0;
      cmd_stb          <= 1'b0;
      if (act && !is_cmd) begin
        o_reg_write_stb <= 1'b1;
        case (i_req.reg_idx)
          REG_STATUS_BUF_ADDR:  o_regs.status_buf_addr <= i_req.data;
          REG_BUFFER_READY: begin
            o_regs.update_buf <= i_req.data[1:0];
            o_update_buf_stb  <= 1'b1;
          end
          REG_WRITE_BUF_A_ADDR: o_regs.write_a_addr <= i_req.data;
          REG_WRITE_BUF_B_ADDR: o_regs.write_b_addr <= i_req.data;
          REG_READ_BUF_A_ADDR:  o_regs.read_a_addr  <= i_req.data;
          REG_READ_BUF_B_ADDR:  o_regs.read_b_addr  <= i_req.data;
          REG_BUFFER_SIZE:      o_regs.buffer_size  <= i_req.data;
          REG_DEV_ADDR:         o_regs.dev_addr     <= i_req.data;
          // Holes in the register map are acknowledged but ignored
          default: ;
        endcase
      end else if (act) begin
        cmd_stb           <= 1'b1;
        o_regs.update_buf <= 2'b00;
        o_update_buf_stb  <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (act && is_cmd) begin
      cmd_kind <= dec_kind;
      cmd_sel  <= dec_sel;
      cmd_fifo <= dec_fifo;
      cmd_data <= i_req.data;
    end
  end

  assign o_cmd = '{stb: cmd_stb, kind: cmd_kind, sel: cmd_sel, fifo: cmd_fifo, data: cmd_data};

endmodule

`default_nettype wire

/* rtl/ingress_fifo.sv */
/*
  Receive buffer sized to the sender's credit pool.
  A push is always taken, so the sender must obey the credit count.
  o_credit_return pulses the cycle after each pop.
*/
`default_nettype none

module ingress_fifo (
  input  wire                             clk,
  input  wire                             rst,
  input  wire                             i_push,
  input  wire pcie_ingress_pkg::ingress_beat_t i_beat,
  input  wire                             i_pop,
  output pcie_ingress_pkg::ingress_beat_t o_beat,
  output logic                            o_not_empty,
  output logic                            o_credit_return
);
  import pcie_ingress_pkg::*;

  ingress_beat_t           mem [INGRESS_CREDITS];
  logic [FIFO_PTR_W-1:0]   wr_ptr;
  logic [FIFO_PTR_W-1:0]   rd_ptr;
  logic [FIFO_PTR_W:0]     count;
  logic                    do_pop;

  assign o_not_empty = (count != '0);
  assign do_pop      = i_pop && o_not_empty;
  assign o_beat      = mem[rd_ptr];

  always_ff @(posedge clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_beat;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr          <= '0;
      rd_ptr          <= '0;
      count           <= '0;
      o_credit_return <= 1'b0;
    end else begin
      o_credit_return <= do_pop;
      if (i_push) begin
        wr_ptr <= wr_ptr + FIFO_PTR_W'(1);
      end
      if (do_pop) begin
        rd_ptr <= rd_ptr + FIFO_PTR_W'(1);
      end
      // Occupancy only moves when push and pop differ
      case ({i_push, do_pop})
        2'b10:   count <= count + (FIFO_PTR_W + 1)'(1);
        2'b01:   count <= count - (FIFO_PTR_W + 1)'(1);
        default: count <= count;
      endcase
    end
  end

endmodule

`default_nettype wire

/* rtl/pcie_ingress_pkg.sv */
/*
  Shared definitions for the PCIe ingress path.
  Header fields follow the TLP layout of 32-bit dwords, most significant byte first.
  Register and command offsets are dword indices from the control window base.
  INGRESS_CREDITS must stay a power of two because the FIFO pointers wrap freely.
*/
`default_nettype none

package pcie_ingress_pkg;

  // Credits granted to the sender, also the receive FIFO depth
  localparam int INGRESS_CREDITS = 8;
  localparam int FIFO_PTR_W      = $clog2(INGRESS_CREDITS);
  localparam int BUF_ADDR_W      = 11;

  // FMT field, header dword 0 bits 30:29
  localparam logic [1:0] FMT_3DW_NO_DATA = 2'b00;
  localparam logic [1:0] FMT_4DW_NO_DATA = 2'b01;
  localparam logic [1:0] FMT_3DW_DATA    = 2'b10;
  localparam logic [1:0] FMT_4DW_DATA    = 2'b11;

  // TYPE field, header dword 0 bits 28:24
  localparam logic [4:0] TYPE_MWR = 5'b00000;
  localparam logic [4:0] TYPE_CPL = 5'b01010;

  // Setup registers in the control window
  localparam logic [31:0] REG_STATUS_BUF_ADDR  = 32'd0;
  localparam logic [31:0] REG_BUFFER_READY     = 32'd1;
  localparam logic [31:0] REG_WRITE_BUF_A_ADDR = 32'd2;
  localparam logic [31:0] REG_WRITE_BUF_B_ADDR = 32'd3;
  localparam logic [31:0] REG_READ_BUF_A_ADDR  = 32'd4;
  localparam logic [31:0] REG_READ_BUF_B_ADDR  = 32'd5;
  localparam logic [31:0] REG_BUFFER_SIZE      = 32'd6;
  localparam logic [31:0] REG_DEV_ADDR         = 32'd7;

  // Command window
  localparam logic [31:0] CMD_OFFSET         = 32'h80;
  localparam logic [31:0] CMD_RESET          = CMD_OFFSET + 32'd0;
  localparam logic [31:0] CMD_PER_WRITE      = CMD_OFFSET + 32'd1;
  localparam logic [31:0] CMD_PER_WRITE_FIFO = CMD_OFFSET + 32'd2;
  localparam logic [31:0] CMD_PER_READ       = CMD_OFFSET + 32'd3;
  localparam logic [31:0] CMD_PER_READ_FIFO  = CMD_OFFSET + 32'd4;
  localparam logic [31:0] CMD_MEM_WRITE      = CMD_OFFSET + 32'd5;
  localparam logic [31:0] CMD_MEM_READ       = CMD_OFFSET + 32'd6;
  localparam logic [31:0] CMD_DMA_WRITE      = CMD_OFFSET + 32'd7;
  localparam logic [31:0] CMD_DMA_READ       = CMD_OFFSET + 32'd8;
  localparam logic [31:0] CMD_PING           = CMD_OFFSET + 32'd9;
  localparam logic [31:0] CMD_READ_CONFIG    = CMD_OFFSET + 32'd10;

  typedef struct packed {
    logic [31:0] data;
    logic        last;
  } ingress_beat_t;

  // Header dword 2 as seen by a completion
  typedef struct packed {
    logic [15:0] requester_id;
    logic [7:0]  tag;
    logic        rsvd;
    logic [6:0]  lower_addr;
  } cpl_dw2_t;

  typedef union packed {
    logic [31:0] mem_addr;
    cpl_dw2_t    cpl;
  } hdr_dw2_u;

  typedef enum logic [2:0] {
    KIND_RESET,
    KIND_WRITE,
    KIND_READ,
    KIND_PING,
    KIND_READ_CONFIG,
    KIND_UNKNOWN
  } cmd_kind_e;

  typedef enum logic [1:0] {
    SEL_NONE,
    SEL_PER,
    SEL_MEM,
    SEL_DMA
  } cmd_sel_e;

  typedef struct packed {
    logic [31:0] status_buf_addr;
    logic [31:0] write_a_addr;
    logic [31:0] write_b_addr;
    logic [31:0] read_a_addr;
    logic [31:0] read_b_addr;
    logic [31:0] buffer_size;
    logic [31:0] dev_addr;
    logic [1:0]  update_buf;
  } ctrl_regs_t;

  typedef struct packed {
    logic        stb;
    cmd_kind_e   kind;
    cmd_sel_e    sel;
    logic        fifo;
    logic [31:0] data;
  } cmd_event_t;

  typedef struct packed {
    logic        stb;
    logic [31:0] data;
    logic        first;
    logic        last;
    logic [31:0] reg_idx;
    logic [7:0]  tag;
    logic [11:0] byte_cnt;
    logic [9:0]  dw_cnt;
    logic [6:0]  lower_addr;
  } route_req_t;

  typedef struct packed {
    logic                  we;
    logic [BUF_ADDR_W-1:0] addr;
    logic [31:0]           data;
  } buf_wr_t;

  typedef struct packed {
    logic        stb;
    logic [7:0]  tag;
    logic [11:0] byte_cnt;
    logic [9:0]  dw_cnt;
  } cplt_info_t;

endpackage

`default_nettype wire

/* rtl/pcie_ingress_top.sv */
/*
  PCIe ingress receive path.
  The sender starts with INGRESS_CREDITS credits and regains one per o_credit_return.
  Beats are never refused, so i_beat_valid without a credit overflows the FIFO.
*/
`default_nettype none

module pcie_ingress_top (
  input  wire                                    clk,
  input  wire                                    rst,
  input  wire                                    i_beat_valid,
  input  wire pcie_ingress_pkg::ingress_beat_t   i_beat,
  input  wire [31:0]                             i_control_addr_base,
  input  wire [pcie_ingress_pkg::BUF_ADDR_W-1:0] i_buf_offset,
  output logic                                   o_credit_return,
  output pcie_ingress_pkg::ctrl_regs_t           o_regs,
  output logic                                   o_reg_write_stb,
  output logic                                   o_update_buf_stb,
  output pcie_ingress_pkg::cmd_event_t           o_cmd,
  output pcie_ingress_pkg::buf_wr_t              o_buf,
  output pcie_ingress_pkg::cplt_info_t           o_cplt
);
  import pcie_ingress_pkg::*;

  ingress_beat_t fifo_beat;
  logic          fifo_not_empty;
  logic          fifo_pop;
  route_req_t    reg_req;
  route_req_t    cpl_req;
  logic          reg_done;
  logic          cpl_done;

  ingress_fifo u_fifo (
    .clk             (clk),
    .rst             (rst),
    .i_push          (i_beat_valid),
    .i_beat          (i_beat),
    .i_pop           (fifo_pop),
    .o_beat          (fifo_beat),
    .o_not_empty     (fifo_not_empty),
    .o_credit_return (o_credit_return)
  );

  tlp_router u_router (
    .clk                 (clk),
    .rst                 (rst),
    .i_beat              (fifo_beat),
    .i_not_empty         (fifo_not_empty),
    .i_control_addr_base (i_control_addr_base),
    .i_reg_done          (reg_done),
    .i_cpl_done          (cpl_done),
    .o_pop               (fifo_pop),
    .o_reg_req           (reg_req),
    .o_cpl_req           (cpl_req)
  );

  ctrl_reg_decoder u_reg_dec (
    .clk              (clk),
    .rst              (rst),
    .i_req            (reg_req),
    .o_done           (reg_done),
    .o_regs           (o_regs),
    .o_reg_write_stb  (o_reg_write_stb),
    .o_update_buf_stb (o_update_buf_stb),
    .o_cmd            (o_cmd)
  );

  cpl_buffer_writer u_cpl_wr (
    .clk          (clk),
    .rst          (rst),
    .i_req        (cpl_req),
    .i_buf_offset (i_buf_offset),
    .o_done       (cpl_done),
    .o_buf        (o_buf),
    .o_cplt       (o_cplt)
  );

endmodule

`default_nettype wire

/* rtl/tlp_router.sv */
/*
  Header capture and TLP steering.
  MWr payload goes to the register decoder, CplD payload to the buffer writer,
  everything else is popped and dropped up to its last dword.
  A routed packet ends on the handler's done pulse, then one idle cycle follows.
*/
`default_nettype none

module tlp_router (
  input  wire                                  clk,
  input  wire                                  rst,
  input  wire pcie_ingress_pkg::ingress_beat_t i_beat,
  input  wire                                  i_not_empty,
  input  wire [31:0]                           i_control_addr_base,
  input  wire                                  i_reg_done,
  input  wire                                  i_cpl_done,
  output logic                                 o_pop,
  output pcie_ingress_pkg::route_req_t         o_reg_req,
  output pcie_ingress_pkg::route_req_t         o_cpl_req
);
  import pcie_ingress_pkg::*;

  typedef enum logic [1:0] {
    S_HDR,
    S_PAYLOAD,
    S_DRAIN,
    S_GAP
  } state_e;

  state_e      state;
  logic [1:0]  hdr_idx;
  logic        to_reg;
  logic        to_cpl;
  logic        first_pending;
  logic [31:0] dw0;
  logic [31:0] dw1;
  hdr_dw2_u    dw2;
  logic [31:0] dw3;
  logic        hdr_4dw;
  logic        hdr_done;
  logic        is_mwr;
  logic        is_cpld;
  logic [31:0] mem_addr;
  route_req_t  req;

  assign o_pop = i_not_empty && (state != S_GAP);

  always_comb begin
    hdr_4dw = 1'b0;
    case (dw0[30:29])
      FMT_3DW_NO_DATA, FMT_3DW_DATA: hdr_4dw = 1'b0;
      FMT_4DW_NO_DATA, FMT_4DW_DATA: hdr_4dw = 1'b1;
    endcase
  end

  // Dword 0 is already stored by the time the header can complete
  assign hdr_done = o_pop && (state == S_HDR) &&
                    ((hdr_idx == 2'd3) || (hdr_idx == 2'd2 && !hdr_4dw));
  assign is_mwr   = (dw0[28:24] == TYPE_MWR) &&
                    ((dw0[30:29] == FMT_3DW_DATA) || (dw0[30:29] == FMT_4DW_DATA));
  assign is_cpld  = (dw0[28:24] == TYPE_CPL) && (dw0[30:29] == FMT_3DW_DATA);
  assign mem_addr = hdr_4dw ? dw3 : dw2.mem_addr;

  always_comb begin
    req.stb        = o_pop && (state == S_PAYLOAD);
    req.data       = i_beat.data;
    req.first      = first_pending;
    req.last       = i_beat.last;
    req.reg_idx    = ({mem_addr[31:2], 2'b00} - i_control_addr_base) >> 2;
    req.tag        = dw2.cpl.tag;
    req.byte_cnt   = dw1[11:0];
    req.dw_cnt     = dw0[9:0];
    req.lower_addr = dw2.cpl.lower_addr;
    o_reg_req      = req;
    o_reg_req.stb  = req.stb && to_reg;
    o_cpl_req      = req;
    o_cpl_req.stb  = req.stb && to_cpl;
  end

  always_ff @(posedge clk) begin
    if (o_pop && state == S_HDR) begin
      case (hdr_idx)
        2'd0:    dw0 <= i_beat.data;
        2'd1:    dw1 <= i_beat.data;
        2'd2:    dw2 <= i_beat.data;
        default: dw3 <= i_beat.data;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state         <= S_HDR;
      hdr_idx       <= 2'd0;
      to_reg        <= 1'b0;
      to_cpl        <= 1'b0;
      first_pending <= 1'b0;
    end else begin
      case (state)
        S_HDR: begin
          if (o_pop) begin
            hdr_idx <= hdr_idx + 2'd1;
            // A last flag inside the header means no payload follows
            if (i_beat.last) begin
              hdr_idx <= 2'd0;
              state   <= S_GAP;
            end else if (hdr_done) begin
              hdr_idx       <= 2'd0;
              to_reg        <= is_mwr;
              to_cpl        <= is_cpld;
              first_pending <= 1'b1;
              state         <= (is_mwr || is_cpld) ? S_PAYLOAD : S_DRAIN;
            end
          end
        end
        S_PAYLOAD: begin
          if (o_pop) begin
            first_pending <= 1'b0;
          end
          if (i_reg_done || i_cpl_done) begin
            state <= S_GAP;
          end
        end
        S_DRAIN: begin
          if (o_pop && i_beat.last) begin
            state <= S_GAP;
          end
        end
        default: state <= S_HDR;
      endcase
    end
  end

endmodule

`default_nettype wire

/* sim/pcie_ingress_properties.sv */
/*
  Concurrent checks on the credit loop and the completion summary.
  The receive FIFO fill level is rebuilt here from beats taken and dwords popped,
  so it does not depend on the credit count the sender keeps.
*/
`default_nettype none

module pcie_ingress_properties (
  input wire clk,
  input wire rst,
  input wire i_beat_valid,
  input wire i_pop,
  input wire i_not_empty,
  input wire i_credit_return,
  input wire i_cplt_stb
);
  timeunit 1ns;
  timeprecision 1ns;
  import pcie_ingress_pkg::*;

  int unsigned beats_in;
  int unsigned pops_out;
  int unsigned credits_out;
  int unsigned fail_cnt = 0;

  always @(posedge clk) begin
    if (rst) begin
      beats_in    <= 0;
      pops_out    <= 0;
      credits_out <= 0;
    end else begin
      if (i_beat_valid) begin
        beats_in <= beats_in + 1;
      end
      if (i_pop && i_not_empty) begin
        pops_out <= pops_out + 1;
      end
      if (i_credit_return) begin
        credits_out <= credits_out + 1;
      end
    end
  end

  // A credit only comes back for a beat that already arrived
  credit_after_beat: assert property (@(posedge clk) disable iff (rst)
    i_credit_return |-> (credits_out < beats_in))
    else begin
      fail_cnt++;
      $error("credit returned with no beat outstanding");
    end

  // Fill level is beats taken minus dwords popped
  push_not_full: assert property (@(posedge clk) disable iff (rst)
    i_beat_valid |-> ((beats_in - pops_out) < INGRESS_CREDITS))
    else begin
      fail_cnt++;
      $error("beat pushed while the receive FIFO is full");
    end

  cplt_single_pulse: assert property (@(posedge clk) disable iff (rst)
    i_cplt_stb |=> !i_cplt_stb)
    else begin
      fail_cnt++;
      $error("completion summary strobe high on consecutive cycles");
    end

endmodule

bind pcie_ingress_top pcie_ingress_properties u_props (
  .clk             (clk),
  .rst             (rst),
  .i_beat_valid    (i_beat_valid),
  .i_pop           (fifo_pop),
  .i_not_empty     (fifo_not_empty),
  .i_credit_return (o_credit_return),
  .i_cplt_stb      (o_cplt.stb)
);

`default_nettype wire

/* sim/tb_pcie_ingress.sv */
/*
  Testbench for the PCIe ingress receive path.
  The sender never has more than INGRESS_CREDITS dwords without a returned credit.
  Only the first MWr payload dword is meaningful, later ones are random filler.
  Expected outputs come from a register and command model kept in this file.
*/
`default_nettype none

module tb_pcie_ingress;
  timeunit 1ns;
  timeprecision 1ns;
  import pcie_ingress_pkg::*;

  localparam logic [31:0]           CTRL_BASE = 32'h0004_2000;
  localparam logic [BUF_ADDR_W-1:0] BUF_BASE  = 11'h120;

  // One expected register or command update
  typedef struct packed {
    logic       is_cmd;
    logic       ubuf_stb;
    ctrl_regs_t regs;
    cmd_event_t cmd;
  } ctrl_exp_t;

  logic                  clk;
  logic                  rst;
  logic                  i_beat_valid;
  ingress_beat_t         i_beat;
  logic [31:0]           i_control_addr_base;
  logic [BUF_ADDR_W-1:0] i_buf_offset;
  logic                  o_credit_return;
  ctrl_regs_t            o_regs;
  logic                  o_reg_write_stb;
  logic                  o_update_buf_stb;
  cmd_event_t            o_cmd;
  buf_wr_t               o_buf;
  cplt_info_t            o_cplt;

  ctrl_exp_t   exp_ctrl_q[$];
  buf_wr_t     exp_buf_q[$];
  cplt_info_t  exp_cplt_q[$];
  logic [31:0] tlp_q[$];
  ctrl_regs_t  model_regs;
  int          seed     = 61;
  int          sent_cnt = 0;
  int          ret_cnt  = 0;
  int          errors   = 0;
  int          checked  = 0;
  int          cycles   = 0;

  pcie_ingress_top u_dut (
    .clk                 (clk),
    .rst                 (rst),
    .i_beat_valid        (i_beat_valid),
    .i_beat              (i_beat),
    .i_control_addr_base (i_control_addr_base),
    .i_buf_offset        (i_buf_offset),
    .o_credit_return     (o_credit_return),
    .o_regs              (o_regs),
    .o_reg_write_stb     (o_reg_write_stb),
    .o_update_buf_stb    (o_update_buf_stb),
    .o_cmd               (o_cmd),
    .o_buf               (o_buf),
    .o_cplt              (o_cplt)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  always @(posedge clk) begin
    if (o_credit_return) begin
      ret_cnt++;
    end
  end

  task automatic report_mismatch(input string name, input logic [255:0] exp_val,
                                 input logic [255:0] got_val);
    errors++;
    $display("Error: %s expected %0h got %0h at %0t", name, exp_val, got_val, $time);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%s at %0t", what, $time);
  endtask

  // Expected effect of a control window write at dword index idx
  function automatic ctrl_exp_t predict_ctrl(input ctrl_regs_t cur, input logic [31:0] idx,
                                             input logic [31:0] d);
    ctrl_exp_t   e;
    logic [31:0] off;
    e      = '0;
    e.regs = cur;
    off    = idx - CMD_OFFSET;
    if (idx < CMD_OFFSET) begin
      case (idx)
        REG_STATUS_BUF_ADDR:  e.regs.status_buf_addr = d;
        REG_BUFFER_READY: begin
          e.regs.update_buf = d[1:0];
          e.ubuf_stb        = 1'b1;
        end
        REG_WRITE_BUF_A_ADDR: e.regs.write_a_addr = d;
        REG_WRITE_BUF_B_ADDR: e.regs.write_b_addr = d;
        REG_READ_BUF_A_ADDR:  e.regs.read_a_addr = d;
        REG_READ_BUF_B_ADDR:  e.regs.read_b_addr = d;
        REG_BUFFER_SIZE:      e.regs.buffer_size = d;
        REG_DEV_ADDR:         e.regs.dev_addr = d;
        default: ;
      endcase
    end else begin
      e.is_cmd          = 1'b1;
      e.ubuf_stb        = 1'b1;
      e.regs.update_buf = 2'b00;
      e.cmd.stb         = 1'b1;
      e.cmd.data        = d;
      e.cmd.kind        = KIND_UNKNOWN;
      e.cmd.sel         = SEL_NONE;
      // Offsets 1 to 8 pair write and read over peripheral, memory and DMA
      case (off)
        32'd0:  e.cmd.kind = KIND_RESET;
        32'd1, 32'd2: begin
          e.cmd.kind = KIND_WRITE;
          e.cmd.sel  = SEL_PER;
          e.cmd.fifo = (off == 32'd2);
        end
        32'd3, 32'd4: begin
          e.cmd.kind = KIND_READ;
          e.cmd.sel  = SEL_PER;
          e.cmd.fifo = (off == 32'd4);
        end
        32'd5, 32'd7: begin
          e.cmd.kind = KIND_WRITE;
          e.cmd.sel  = (off == 32'd5) ? SEL_MEM : SEL_DMA;
        end
        32'd6, 32'd8: begin
          e.cmd.kind = KIND_READ;
          e.cmd.sel  = (off == 32'd6) ? SEL_MEM : SEL_DMA;
        end
        32'd9:  e.cmd.kind = KIND_PING;
        32'd10: e.cmd.kind = KIND_READ_CONFIG;
        default: ;
      endcase
    end
    return e;
  endfunction

  // Called on a falling edge, returns on a falling edge
  task automatic send_beat(input logic [31:0] data, input logic last);
    int gap;
    gap = {$random(seed)} % 3;
    repeat (gap) @(negedge clk);
    while (sent_cnt - ret_cnt >= INGRESS_CREDITS) begin
      @(negedge clk);
    end
    i_beat_valid = 1'b1;
    i_beat       = '{data: data, last: last};
    sent_cnt++;
    @(negedge clk);
    i_beat_valid = 1'b0;
  endtask

  task automatic send_tlp();
    int n;
    int i;
    n = tlp_q.size();
    for (i = 0; i < n; i++) begin
      send_beat(tlp_q[i], i == n - 1);
    end
    tlp_q.delete();
  endtask

  task automatic send_mwr(input logic [31:0] idx, input logic [31:0] data,
                          input logic four_dw, input int len);
    ctrl_exp_t e;
    int        i;
    e          = predict_ctrl(model_regs, idx, data);
    model_regs = e.regs;
    exp_ctrl_q.push_back(e);
    tlp_q.push_back({1'b0, four_dw ? FMT_4DW_DATA : FMT_3DW_DATA, TYPE_MWR, 14'h0, 10'(len)});
    tlp_q.push_back(32'h0000_000f);
    if (four_dw) begin
      tlp_q.push_back(32'h0);
    end
    tlp_q.push_back(CTRL_BASE + (idx << 2));
    tlp_q.push_back(data);
    for (i = 1; i < len; i++) begin
      tlp_q.push_back($random(seed));
    end
    send_tlp();
  endtask

  task automatic send_cpld(input logic [7:0] tag, input logic [6:0] lower_addr, input int len);
    buf_wr_t     w;
    cplt_info_t  c;
    logic [31:0] d;
    int          i;
    tlp_q.push_back({1'b0, FMT_3DW_DATA, TYPE_CPL, 14'h0, 10'(len)});
    tlp_q.push_back({16'h0100, 3'b000, 1'b0, 12'(len * 4)});
    tlp_q.push_back({16'h0000, tag, 1'b0, lower_addr});
    for (i = 0; i < len; i++) begin
      d = $random(seed);
      tlp_q.push_back(d);
      w.we   = 1'b1;
      w.addr = BUF_BASE + BUF_ADDR_W'(lower_addr >> 2) + BUF_ADDR_W'(i);
      w.data = d;
      exp_buf_q.push_back(w);
    end
    c = '{stb: 1'b1, tag: tag, byte_cnt: 12'(len * 4), dw_cnt: 10'(len)};
    exp_cplt_q.push_back(c);
    send_tlp();
  endtask

  // 0 MRd 3DW, 1 MRd 4DW, 2 MsgD with two dwords, 3 Cpl without data
  task automatic send_drained(input int kind);
    case (kind)
      0: begin
        // MRd shares the type code with MWr
        tlp_q.push_back({1'b0, FMT_3DW_NO_DATA, 5'b00000, 14'h0, 10'd1});
        tlp_q.push_back(32'h0000_000f);
        tlp_q.push_back(CTRL_BASE);
      end
      1: begin
        tlp_q.push_back({1'b0, FMT_4DW_NO_DATA, 5'b00000, 14'h0, 10'd1});
        tlp_q.push_back(32'h0000_000f);
        tlp_q.push_back(32'h0);
        tlp_q.push_back(CTRL_BASE + 32'd4);
      end
      2: begin
        tlp_q.push_back({1'b0, FMT_4DW_DATA, 5'b10000, 14'h0, 10'd2});
        tlp_q.push_back(32'h0000_007f);
        tlp_q.push_back(32'h0);
        tlp_q.push_back(32'h0);
        tlp_q.push_back($random(seed));
        tlp_q.push_back($random(seed));
      end
      default: begin
        tlp_q.push_back({1'b0, FMT_3DW_NO_DATA, TYPE_CPL, 14'h0, 10'd0});
        tlp_q.push_back(32'h0100_0004);
        tlp_q.push_back(32'h0000_0500);
      end
    endcase
    send_tlp();
  endtask

  // Output checker, sampled mid-cycle
  always @(negedge clk) begin
    ctrl_exp_t  ce;
    buf_wr_t    bw;
    cplt_info_t ci;
    if (!rst) begin
      if (o_reg_write_stb || o_update_buf_stb || o_cmd.stb) begin
        if (exp_ctrl_q.size() == 0) begin
          report_failure("Register or command strobe with no write pending");
        end else begin
          ce = exp_ctrl_q.pop_front();
          checked++;
          if (o_reg_write_stb !== !ce.is_cmd) begin
            report_mismatch("o_reg_write_stb", 256'(!ce.is_cmd), 256'(o_reg_write_stb));
          end
          if (o_update_buf_stb !== ce.ubuf_stb) begin
            report_mismatch("o_update_buf_stb", 256'(ce.ubuf_stb), 256'(o_update_buf_stb));
          end
          if (o_regs !== ce.regs) begin
            report_mismatch("o_regs", 256'(ce.regs), 256'(o_regs));
          end
          if (o_cmd.stb !== ce.is_cmd) begin
            report_mismatch("o_cmd.stb", 256'(ce.is_cmd), 256'(o_cmd.stb));
          end else if (ce.is_cmd && o_cmd !== ce.cmd) begin
            report_mismatch("o_cmd", 256'(ce.cmd), 256'(o_cmd));
          end
        end
      end
      if (o_buf.we) begin
        if (exp_buf_q.size() == 0) begin
          report_failure("Buffer write with no completion payload pending");
        end else begin
          bw = exp_buf_q.pop_front();
          checked++;
          if (o_buf.addr !== bw.addr) begin
            report_mismatch("o_buf.addr", 256'(bw.addr), 256'(o_buf.addr));
          end
          if (o_buf.data !== bw.data) begin
            report_mismatch("o_buf.data", 256'(bw.data), 256'(o_buf.data));
          end
        end
      end
      if (o_cplt.stb) begin
        if (exp_cplt_q.size() == 0) begin
          report_failure("Completion summary with no completion pending");
        end else begin
          ci = exp_cplt_q.pop_front();
          checked++;
          if (o_cplt !== ci) begin
            report_mismatch("o_cplt", 256'(ci), 256'(o_cplt));
          end
        end
      end
    end
  end

  // Watchdog, 40 cycles per sent dword plus margin for reset and drain
  initial begin
    while (cycles <= 40 * (sent_cnt + 8)) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout after %0d cycles, %0d of %0d credits returned",
             cycles, ret_cnt, sent_cnt);
    $display("Checked %0d outputs, sent %0d dwords, %0d errors", checked, sent_cnt, errors);
    $display("STATUS: FAIL");
    $finish;
  end

  initial begin
    int i;
    int pick;
    rst                 = 1'b1;
    i_beat_valid        = 1'b0;
    i_beat              = '0;
    i_control_addr_base = CTRL_BASE;
    i_buf_offset        = BUF_BASE;
    model_regs          = '0;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    @(negedge clk);

    checked++;
    if (o_credit_return || o_reg_write_stb || o_update_buf_stb || o_cmd.stb ||
        o_buf.we || o_cplt.stb) begin
      report_failure("A strobe or credit return is high after reset");
    end
    if (o_regs !== '0) begin
      report_mismatch("o_regs", '0, 256'(o_regs));
    end

    // Each setup register through both header sizes, plus a hole in the map
    for (i = 0; i < 8; i++) begin
      send_mwr(32'(i), $random(seed), 1'b0, 1);
      send_mwr(32'(i), $random(seed), 1'b1, 2);
    end
    send_mwr(32'd12, $random(seed), 1'b0, 1);

    for (i = 0; i <= 10; i++) begin
      send_mwr(CMD_OFFSET + 32'(i), $random(seed), 1'(i), 1);
    end
    send_mwr(CMD_OFFSET + 32'd20, $random(seed), 1'b0, 1);

    for (i = 1; i <= 8; i++) begin
      send_cpld(8'(i), 7'(i * 12), i);
    end
    for (i = 0; i < 4; i++) begin
      send_drained(i);
    end

    // Random mix
    for (i = 0; i < 40; i++) begin
      pick = {$random(seed)} % 4;
      case (pick)
        0: send_mwr({$random(seed)} % 8, $random(seed), 1'($random(seed)),
                    1 + {$random(seed)} % 3);
        1: send_mwr(CMD_OFFSET + {$random(seed)} % 12, $random(seed), 1'($random(seed)), 1);
        2: send_cpld(8'($random(seed)), 7'($random(seed)), 1 + {$random(seed)} % 8);
        default: send_drained({$random(seed)} % 4);
      endcase
    end

    while (ret_cnt != sent_cnt || exp_ctrl_q.size() != 0 || exp_buf_q.size() != 0 ||
           exp_cplt_q.size() != 0) begin
      @(negedge clk);
    end
    repeat (10) @(negedge clk);

    if (ret_cnt != sent_cnt) begin
      report_mismatch("credit returns", 256'(sent_cnt), 256'(ret_cnt));
    end
    if (u_dut.u_props.fail_cnt != 0) begin
      report_failure("Bound assertions failed during the run");
    end

    $display("Checked %0d outputs, sent %0d dwords, %0d errors", checked, sent_cnt, errors);
    if (errors == 0) begin
      $display("STATUS: PASS");
    end else begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* verilog.f */
rtl/pcie_ingress_pkg.sv
rtl/ingress_fifo.sv
rtl/tlp_router.sv
rtl/ctrl_reg_decoder.sv
rtl/cpl_buffer_writer.sv
rtl/pcie_ingress_top.sv
sim/pcie_ingress_properties.sv
sim/tb_pcie_ingress.sv
